//--- verilog.f
+incdir+tests
design/trapPkg.sv
design/csrBusIf.sv
design/interruptArbiter.sv
design/csrCounters.sv
design/csrFile.sv
design/trapController.sv
design/trapUnitTop.sv
tests/trapUnitTb.sv

//--- run.sh
#!/bin/bash
# Build and run the trap unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module trapUnitTb -Mdir obj_dir -o trapUnitSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/trapUnitSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

//--- tests/trapModel.svh
// Reference model of the machine CSR state, the counters and the request handshake
// Included in the testbench module, reads the DUT input signals directly
// Stepped once per rising edge with the input values from before that edge

typedef enum logic [1:0] {
    stageIdle,
    stageAck,
    stageWait
} stageKind;

stageKind modelPhase;
logic     modelIe;
logic     modelPie;
logic     modelMtie;
logic     modelMeie;
logic     modelMtip;
logic     modelMeip;
dataWord  modelMcause;
dataWord  modelMtvec;
dataWord  modelMtval;
dataWord  modelMepc;
dataWord  modelMscratch;
dataWord  modelMcycle;
dataWord  modelMinstret;

// Expected registered outputs
logic     expRedirect;
dataWord  expReadData;
dataWord  expRedirectAddr;
logic     addrHeld;          // redirectAddr belongs to the current handshake

function automatic dataWord readCsr(input csrNumber n);
    case (n)
        csrMstatus:  return {24'd0, modelPie, 3'd0, modelIe, 3'd0};
        csrMie:      return {20'd0, modelMeie, 3'd0, modelMtie, 7'd0};
        csrMip:      return {20'd0, modelMeip, 3'd0, modelMtip, 7'd0};
        csrMcause:   return modelMcause;
        csrMtvec:    return modelMtvec;
        csrMtval:    return modelMtval;
        csrMepc:     return modelMepc;
        csrMscratch: return modelMscratch;
        csrMcycle:   return modelMcycle;
        csrMinstret: return modelMinstret;
        default:     return '0;
    endcase
endfunction

function automatic void resetModel();
    modelPhase      = stageIdle;
    {modelIe, modelPie, modelMtie, modelMeie, modelMtip, modelMeip} = '0;
    modelMcause     = '0;
    modelMtvec      = '0;
    modelMtval      = '0;
    modelMepc       = '0;
    modelMscratch   = '0;
    modelMcycle     = '0;
    modelMinstret   = '0;
    expRedirect     = 1'b0;
    expReadData     = '0;
    expRedirectAddr = '0;
    addrHeld        = 1'b0;
endfunction

function automatic void stepModel();
    dataWord oldValue;
    dataWord newValue;
    logic    accept;
    logic    timerOn;
    logic    externalOn;
    logic    takeIrq;

    oldValue   = readCsr(number);
    timerOn    = modelMtip && modelMtie;
    externalOn = modelMeip && modelMeie;
    accept     = (modelPhase == stageIdle) && req;
    takeIrq    = (modelPhase == stageIdle) && !req && modelIe && (timerOn || externalOn);
    case (code)
        csrSet:   newValue = oldValue | writeData;
        csrClear: newValue = oldValue & ~writeData;
        default:  newValue = writeData;
    endcase

    expRedirect = (accept && (kind != opCsr)) || takeIrq;
    if (accept) begin
        expReadData = oldValue;  // Value before the update
        addrHeld    = (kind != opCsr);
    end
    if (accept && (kind == opMret)) begin
        expRedirectAddr = modelMepc;
    end else if (expRedirect) begin
        expRedirectAddr = modelMtvec;
    end

    modelMcycle   = modelMcycle + 32'd1;
    modelMinstret = modelMinstret + dataWord'(commitNum);

    if (takeIrq || (accept && (kind == opTrap))) begin
        modelPie   = modelIe;
        modelIe    = 1'b0;
        modelMepc  = takeIrq ? retireAddr : causeAddr;
        modelMtval = takeIrq ? retireAddr : causeData;
        if (takeIrq) begin
            modelMcause = {1'b1, 27'd0, externalOn ? irqExternal : irqTimer};  // External first
        end else begin
            modelMcause = {28'd0, cause};
        end
    end else if (accept && (kind == opMret)) begin
        modelIe = modelPie;
    end else if (accept) begin
        case (number)
            csrMstatus: begin
                modelIe  = newValue[3];
                modelPie = newValue[7];
            end
            csrMie: begin
                modelMtie = newValue[7];
                modelMeie = newValue[11];
            end
            csrMcause:   modelMcause   = newValue;
            csrMtvec:    modelMtvec    = {newValue[31:2], 2'b00};
            csrMtval:    modelMtval    = newValue;
            csrMepc:     modelMepc     = newValue;
            csrMscratch: modelMscratch = newValue;
            csrMcycle:   modelMcycle   = newValue;  // Write wins over the increment
            csrMinstret: modelMinstret = newValue;
            default: ;                              // mip ignores writes
        endcase
    end

    modelMtip = timerIrq;
    modelMeip = externalIrq;

    case (modelPhase)
        stageIdle: modelPhase = req ? stageAck : stageIdle;
        stageAck:  modelPhase = req ? stageAck : stageWait;
        default:   modelPhase = stageIdle;
    endcase
endfunction

//--- tests/trapUnitTb.sv
// Testbench for the machine-mode trap unit
// Random CSR, trap and MRET requests over the req/ack handshake
// Random interrupt levels and commit counts, checked against a reference model
`timescale 1ns/1ps

module trapUnitTb;
    import trapPkg::*;

    localparam int numTrans   = 400;
    localparam int cycleLimit = numTrans * 12 + 100;
    localparam int randomSeed = 40;
    localparam int halfPeriod = 2;

    logic       clk;
    logic       reset;
    logic       req;
    opKind      kind;
    csrNumber   number;
    csrCode     code;
    dataWord    writeData;
    dataWord    causeAddr;
    dataWord    causeData;
    trapCause   cause;
    dataWord    retireAddr;
    logic       timerIrq;
    logic       externalIrq;
    logic [1:0] commitNum;
    logic       ack;
    dataWord    readData;
    logic       redirect;
    dataWord    redirectAddr;
    int         cycleCount = 0;
    csrNumber   lastNumber;

    `include "trapModel.svh"

    trapUnitTop #(
        .commitWidth (2)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .kind         (kind),
        .number       (number),
        .code         (code),
        .writeData    (writeData),
        .causeAddr    (causeAddr),
        .causeData    (causeData),
        .cause        (cause),
        .retireAddr   (retireAddr),
        .timerIrq     (timerIrq),
        .externalIrq  (externalIrq),
        .commitNum    (commitNum),
        .ack          (ack),
        .readData     (readData),
        .redirect     (redirect),
        .redirectAddr (redirectAddr)
    );

    always #halfPeriod clk = ~clk;

    task automatic compareValue(input string name, input dataWord actual, input dataWord expected);
        if (actual !== expected) begin
            $display("mismatch %s: actual %h expected %h", name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first failing check");
        end
    endtask

    function automatic csrNumber pickNumber();
        case ($urandom_range(0, 9))
            0:       return csrMstatus;
            1:       return csrMie;
            2:       return csrMip;
            3:       return csrMcause;
            4:       return csrMtvec;
            5:       return csrMtval;
            6:       return csrMepc;
            7:       return csrMscratch;
            8:       return csrMcycle;
            default: return csrMinstret;
        endcase
    endfunction

    function automatic trapCause pickCause();
        case ($urandom_range(0, 4))
            0:       return causeIllegal;
            1:       return causeBreakpoint;
            2:       return causeLoadMisaligned;
            3:       return causeStoreMisaligned;
            default: return causeEcall;
        endcase
    endfunction

    // One clock edge, then new commit count and occasional irq level changes
    task automatic stepClock();
        @(posedge clk);
        commitNum <= 2'($urandom_range(0, 3));
        if ($urandom_range(0, 7) == 0) begin
            timerIrq <= ~timerIrq;
        end
        if ($urandom_range(0, 7) == 0) begin
            externalIrq <= ~externalIrq;
        end
    endtask

    // Full four-phase handshake, starting at the current edge
    task automatic sendRequest(input opKind k, input csrNumber n, input csrCode c, input dataWord d);
        int hold;

        hold = $urandom_range(0, 2);
        req        <= 1'b1;
        kind       <= k;
        number     <= n;
        code       <= c;
        writeData  <= d;
        causeAddr  <= $urandom();
        causeData  <= $urandom();
        cause      <= pickCause();
        retireAddr <= $urandom();
        do stepClock(); while (!ack);
        repeat (hold) stepClock();  // Back-pressure
        req <= 1'b0;
        do stepClock(); while (ack);
    endtask

    // Model check and step on every edge
    always @(posedge clk) begin
        if (reset) begin
            resetModel();
        end else begin
            compareValue("ack", {31'd0, ack}, {31'd0, modelPhase != stageIdle});
            compareValue("redirect", {31'd0, redirect}, {31'd0, expRedirect});
            if (ack) begin
                compareValue("readData", readData, expReadData);
            end
            if (redirect || (ack && addrHeld)) begin
                compareValue("redirectAddr", redirectAddr, expRedirectAddr);
            end
            stepModel();
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("ERRORS FOUND");
            $fatal(1, "timeout after %0d cycles without finishing", cycleCount);
        end
    end

    initial begin
        int choice;

        clk         = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        kind        = opCsr;
        number      = csrMstatus;
        code        = csrWrite;
        writeData   = '0;
        causeAddr   = '0;
        causeData   = '0;
        cause       = causeIllegal;
        retireAddr  = '0;
        timerIrq    = 1'b0;
        externalIrq = 1'b0;
        commitNum   = '0;
        lastNumber  = csrMstatus;
        void'($urandom(randomSeed));

        repeat (3) stepClock();
        reset <= 1'b0;

        for (int i = 0; i < numTrans; i++) begin
            repeat ($urandom_range(0, 3)) stepClock();  // Idle gap for interrupts
            choice = $urandom_range(0, 9);
            if (choice < 4) begin
                lastNumber = pickNumber();
                sendRequest(opCsr, lastNumber, csrCode'(2'($urandom_range(1, 3))), $urandom());
            end else if (choice < 6) begin
                sendRequest(opCsr, lastNumber, csrSet, '0);  // Plain read back
            end else if (choice < 8) begin
                sendRequest(opTrap, lastNumber, csrWrite, $urandom());
            end else begin
                sendRequest(opMret, lastNumber, csrWrite, $urandom());
            end
        end
        stepClock();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- design/trapUnitTop.sv
// Top level of the machine-mode trap unit
// Connects controller, CSR file, counters and interrupt arbiter
`timescale 1ns/1ps

module trapUnitTop #(
    parameter int commitWidth = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  trapPkg::opKind         kind,
    input  trapPkg::csrNumber      number,
    input  trapPkg::csrCode        code,
    input  trapPkg::dataWord       writeData,
    input  trapPkg::dataWord       causeAddr,
    input  trapPkg::dataWord       causeData,
    input  trapPkg::trapCause      cause,
    input  trapPkg::dataWord       retireAddr,
    input  logic                   timerIrq,
    input  logic                   externalIrq,
    input  logic [commitWidth-1:0] commitNum,
    output logic                   ack,
    output trapPkg::dataWord       readData,
    output logic                   redirect,
    output trapPkg::dataWord       redirectAddr
);

    csrBusIf bus0 ();

    trapController controller0 (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .kind         (kind),
        .number       (number),
        .code         (code),
        .writeData    (writeData),
        .causeAddr    (causeAddr),
        .causeData    (causeData),
        .retireAddr   (retireAddr),
        .cause        (cause),
        .ack          (ack),
        .readData     (readData),
        .redirect     (redirect),
        .redirectAddr (redirectAddr),
        .bus          (bus0.ctrl)
    );

    csrFile file0 (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus0.file),
        .timerIrq    (timerIrq),
        .externalIrq (externalIrq)
    );

    csrCounters #(
        .commitWidth (commitWidth)
    ) counters0 (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus0.counters),
        .commitNum (commitNum)
    );

    interruptArbiter arbiter0 (
        .bus (bus0.arbiter)
    );

endmodule

//--- design/trapController.sv
// Request handshake FSM for the trap unit
// Accepts CSR, trap and MRET requests, takes interrupts when idle
// Issues one strobe per event and drives the redirect pulse
`timescale 1ns/1ps

module trapController (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  trapPkg::opKind    kind,
    input  trapPkg::csrNumber number,
    input  trapPkg::csrCode   code,
    input  trapPkg::dataWord  writeData,
    input  trapPkg::dataWord  causeAddr,
    input  trapPkg::dataWord  causeData,
    input  trapPkg::dataWord  retireAddr,
    input  trapPkg::trapCause cause,
    output logic              ack,
    output trapPkg::dataWord  readData,
    output logic              redirect,
    output trapPkg::dataWord  redirectAddr,
    csrBusIf.ctrl             bus
);
    import trapPkg::*;

    typedef enum logic [1:0] {
        idle,
        ackHigh,
        waitLow
    } ctrlState;

    ctrlState state;
    logic     accept;
    logic     takeIrq;

    assign accept  = (state == idle) && req;
    assign takeIrq = (state == idle) && !req && bus.irqPending;  // Never during a handshake

    // Strobes are valid in the accepting cycle, committed at its edge
    assign bus.doCsr  = accept && (kind == opCsr);
    assign bus.doTrap = accept && (kind == opTrap);
    assign bus.doMret = accept && (kind == opMret);
    assign bus.doIrq  = takeIrq;

    // Request fields go straight through
    assign bus.number     = number;
    assign bus.code       = code;
    assign bus.writeData  = writeData;
    assign bus.causeAddr  = causeAddr;
    assign bus.causeData  = causeData;
    assign bus.cause      = cause;
    assign bus.retireAddr = retireAddr;

    assign ack = (state != idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            redirect <= 1'b0;
        end else begin
            redirect <= bus.doTrap || bus.doMret || takeIrq;
            case (state)
                idle: begin
                    if (req) begin
                        state <= ackHigh;
                    end
                end
                ackHigh: begin
                    if (!req) begin
                        state <= waitLow;  // Core has let go
                    end
                end
                waitLow: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Payload held for the rest of the handshake
    always_ff @(posedge clk) begin
        if (accept) begin
            readData <= bus.readData;  // Value from before the update
        end
        if (bus.doMret) begin
            redirectAddr <= bus.mepc;
        end else if (bus.doTrap || takeIrq) begin
            redirectAddr <= bus.mtvec;
        end
    end

endmodule

//--- design/csrFile.sv
// Machine-mode CSR storage and read multiplexer
// Write, set and clear on the addressed register
// Trap, interrupt and MRET updates of mstatus, mepc, mtval, mcause
// Counter write strobe for the counter block
`timescale 1ns/1ps

module csrFile (
    input logic   clk,
    input logic   reset,
    csrBusIf.file bus,
    input logic   timerIrq,
    input logic   externalIrq
);
    import trapPkg::*;

    mstatusReg   mstatus;
    mieReg       mieEnable;
    mipReg       mipPending;
    mcauseReg    mcause;
    logic [29:0] mtvecBase;
    dataWord     mtval;
    dataWord     mepc;
    dataWord     mscratch;

    dataWord     readValue;
    dataWord     writeValue;
    mstatusReg   writeStatus;
    mieReg       writeEnable;

    // Read side
    always_comb begin
        case (bus.number)
            csrMstatus:  readValue = mstatus;
            csrMie:      readValue = mieEnable;
            csrMip:      readValue = mipPending;
            csrMcause:   readValue = mcause;
            csrMtvec:    readValue = {mtvecBase, mtvecPadding};
            csrMtval:    readValue = mtval;
            csrMepc:     readValue = mepc;
            csrMscratch: readValue = mscratch;
            csrMcycle,
            csrMinstret: readValue = bus.counterRead;
            default:     readValue = '0;
        endcase
    end

    // Value that a CSR operation would write
    always_comb begin
        case (bus.code)
            csrSet:   writeValue = readValue | bus.writeData;
            csrClear: writeValue = readValue & ~bus.writeData;
            default:  writeValue = bus.writeData;
        endcase
    end

    assign writeStatus = writeValue;
    assign writeEnable = writeValue;

    assign bus.counterWrite = bus.doCsr &&
                              ((bus.number == csrMcycle) || (bus.number == csrMinstret));
    assign bus.counterData  = writeValue;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus    <= '0;
            mieEnable  <= '0;
            mipPending <= '0;
            mcause     <= '0;
            mtvecBase  <= '0;
            mtval      <= '0;
            mepc       <= '0;
            mscratch   <= '0;
        end else begin
            // Pending bits track the interrupt lines
            mipPending.MTIP <= timerIrq;
            mipPending.MEIP <= externalIrq;

            if (bus.doTrap || bus.doIrq) begin
                mstatus.MPIE       <= mstatus.MIE;
                mstatus.MIE        <= 1'b0;
                mcause.isInterrupt <= bus.doIrq;
                if (bus.doIrq) begin
                    mepc                    <= bus.retireAddr;
                    mtval                   <= bus.retireAddr;
                    mcause.code.irq.zero    <= '0;
                    mcause.code.irq.code    <= bus.irqSel;
                end else begin
                    mepc                    <= bus.causeAddr;
                    mtval                   <= bus.causeData;
                    mcause.code.trap.zero   <= '0;
                    mcause.code.trap.code   <= bus.cause;
                end
            end else if (bus.doMret) begin
                mstatus.MIE <= mstatus.MPIE;  // Back to the pre-trap enable
            end else if (bus.doCsr) begin
                case (bus.number)
                    csrMstatus: begin
                        mstatus.MIE  <= writeStatus.MIE;
                        mstatus.MPIE <= writeStatus.MPIE;
                    end
                    csrMie: begin
                        mieEnable.MTIE <= writeEnable.MTIE;
                        mieEnable.MEIE <= writeEnable.MEIE;
                    end
                    csrMcause:   mcause    <= writeValue;
                    csrMtvec:    mtvecBase <= writeValue[31:2];
                    csrMtval:    mtval     <= writeValue;
                    csrMepc:     mepc      <= writeValue;
                    csrMscratch: mscratch  <= writeValue;
                    default: ;  // mip is read only, counters live elsewhere
                endcase
            end
        end
    end

    assign bus.readData   = readValue;
    assign bus.mepc       = mepc;
    assign bus.mtvec      = {mtvecBase, mtvecPadding};
    assign bus.mstatusMie = mstatus.MIE;
    assign bus.mie        = mieEnable;
    assign bus.mip        = mipPending;

endmodule

//--- design/csrCounters.sv
// mcycle and minstret counters
// Software write takes priority over the per-cycle increment
`timescale 1ns/1ps

module csrCounters #(
    parameter int commitWidth = 2
) (
    input logic                   clk,
    input logic                   reset,
    csrBusIf.counters             bus,
    input logic [commitWidth-1:0] commitNum
);
    import trapPkg::*;

    dataWord mcycle;
    dataWord minstret;

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (bus.counterWrite && (bus.number == csrMcycle)) begin
                mcycle <= bus.counterData;
            end else begin
                mcycle <= mcycle + 32'd1;
            end

            // Retired count from the commit stage, zero-extended
            if (bus.counterWrite && (bus.number == csrMinstret)) begin
                minstret <= bus.counterData;
            end else begin
                minstret <= minstret + dataWord'(commitNum);
            end
        end
    end

    assign bus.counterRead = (bus.number == csrMcycle) ? mcycle : minstret;

endmodule

//--- design/interruptArbiter.sv
// Interrupt arbitration for machine mode
// Combines pending, enable and global enable bits
// External interrupt has priority over timer
`timescale 1ns/1ps

module interruptArbiter (
    csrBusIf.arbiter bus
);
    import trapPkg::*;

    logic timerReady;
    logic externalReady;

    assign timerReady    = bus.mip.MTIP && bus.mie.MTIE;
    assign externalReady = bus.mip.MEIP && bus.mie.MEIE;

    // Global enable gates both sources
    assign bus.irqPending = bus.mstatusMie && (timerReady || externalReady);

    always_comb begin
        if (externalReady) begin
            bus.irqSel = irqExternal;
        end else begin
            bus.irqSel = irqTimer;  // Only meaningful when irqPending
        end
    end

endmodule

//--- design/csrBusIf.sv
// Internal bus between the trap controller and the CSR datapath
// Modports for controller, CSR file, counters and interrupt arbiter
`timescale 1ns/1ps

interface csrBusIf;
    import trapPkg::*;

    // Strobes and request fields from the controller
    logic      doCsr;
    logic      doTrap;
    logic      doMret;
    logic      doIrq;
    csrNumber  number;
    csrCode    code;
    dataWord   writeData;
    dataWord   causeAddr;
    dataWord   causeData;
    trapCause  cause;
    dataWord   retireAddr;

    // CSR file state seen by the others
    dataWord   readData;
    dataWord   mepc;
    dataWord   mtvec;
    logic      mstatusMie;
    mieReg     mie;
    mipReg     mip;

    logic      counterWrite;    // Software write to mcycle or minstret
    dataWord   counterData;
    dataWord   counterRead;

    logic      irqPending;
    irqCode    irqSel;

    modport ctrl (
        output doCsr, doTrap, doMret, doIrq, number, code, writeData,
        output causeAddr, causeData, cause, retireAddr,
        input  readData, mepc, mtvec, irqPending
    );

    modport file (
        input  doCsr, doTrap, doMret, doIrq, number, code, writeData,
        input  causeAddr, causeData, cause, retireAddr, irqSel, counterRead,
        output readData, mepc, mtvec, mstatusMie, mie, mip, counterWrite, counterData
    );

    modport counters (
        input  number, counterWrite, counterData,
        output counterRead
    );

    modport arbiter (
        input  mip, mie, mstatusMie,
        output irqPending, irqSel
    );

endinterface

//--- design/trapPkg.sv
// Shared types for the machine-mode trap and CSR subsystem
// CSR numbers, request and operation kinds, cause codes
// Register layouts for mstatus, mie, mip and mcause
package trapPkg;

    typedef logic [31:0] dataWord;
    typedef logic [11:0] csrNumber;

    // Machine CSR addresses
    localparam csrNumber csrMstatus  = 12'h300;
    localparam csrNumber csrMie      = 12'h304;
    localparam csrNumber csrMtvec    = 12'h305;
    localparam csrNumber csrMscratch = 12'h340;
    localparam csrNumber csrMepc     = 12'h341;
    localparam csrNumber csrMcause   = 12'h342;
    localparam csrNumber csrMtval    = 12'h343;
    localparam csrNumber csrMip      = 12'h344;
    localparam csrNumber csrMcycle   = 12'hB00;
    localparam csrNumber csrMinstret = 12'hB02;

    typedef enum logic [1:0] {
        opCsr  = 2'd0,
        opTrap = 2'd1,
        opMret = 2'd2
    } opKind;

    // Same encoding as funct3 of the Zicsr instructions
    typedef enum logic [1:0] {
        csrWrite = 2'd1,
        csrSet   = 2'd2,
        csrClear = 2'd3
    } csrCode;

    typedef enum logic [3:0] {
        causeIllegal         = 4'd2,
        causeBreakpoint      = 4'd3,
        causeLoadMisaligned  = 4'd4,
        causeStoreMisaligned = 4'd6,
        causeEcall           = 4'd11
    } trapCause;

    typedef enum logic [3:0] {
        irqTimer    = 4'd7,
        irqExternal = 4'd11
    } irqCode;

    // mcause code field, read as interrupt or exception code
    typedef union packed {
        struct packed {
            logic [26:0] zero;
            irqCode      code;
        } irq;
        struct packed {
            logic [26:0] zero;
            trapCause    code;
        } trap;
    } mcauseCode;

    typedef struct packed {
        logic      isInterrupt;
        mcauseCode code;
    } mcauseReg;

    typedef struct packed {
        logic [23:0] reservedHigh;
        logic        MPIE;          // Bit 7
        logic [2:0]  reservedMid;
        logic        MIE;           // Bit 3
        logic [2:0]  reservedLow;
    } mstatusReg;

    typedef struct packed {
        logic [19:0] reservedHigh;
        logic        MEIP;          // Bit 11
        logic [2:0]  reservedMid;
        logic        MTIP;          // Bit 7
        logic [6:0]  reservedLow;
    } mipReg;

    typedef struct packed {
        logic [19:0] reservedHigh;
        logic        MEIE;
        logic [2:0]  reservedMid;
        logic        MTIE;
        logic [6:0]  reservedLow;
    } mieReg;

    // Direct mode only, so the low two bits of mtvec are zero
    localparam logic [1:0] mtvecPadding = 2'b00;

endpackage
